// File: hw/fpu_params.svh
`ifndef FPU_PARAMS_SVH
`define FPU_PARAMS_SVH

// ----------------------------------------
// Datapath widths
// ----------------------------------------
`define FPU_FLEN 64
`define FPU_RNID_W 6
`define FPU_CMT_ID_W 5

// Pipe shape
`define FPU_NUM_SRC 2
`define FPU_WB_BUS_NUM 2

// Single-precision quiet NaN, NaN-boxed
`define FPU_CANON_NAN_S 64'hffff_ffff_7fc0_0000

`endif

// File: hw/fpu_op_pkg.sv
package fpu_op_pkg;

  // ----------------------------------------
  // Fast-path opcodes
  // ----------------------------------------
  typedef enum logic [3:0] {
    // Register moves
    OP_FMV_X_W  = 4'd0,
    OP_FMV_W_X  = 4'd1,
    OP_FMV_X_D  = 4'd2,
    OP_FMV_D_X  = 4'd3,
    // Single-precision sign injection
    OP_FSGNJ_S  = 4'd4,
    OP_FSGNJN_S = 4'd5,
    OP_FSGNJX_S = 4'd6,
    // Double-precision sign injection
    OP_FSGNJ_D  = 4'd7,
    OP_FSGNJN_D = 4'd8,
    OP_FSGNJX_D = 4'd9
  } fpu_op_t;

endpackage

// File: hw/fpu_pipe_pkg.sv
`include "fpu_params.svh"

package fpu_pipe_pkg;

  // Register bank select
  typedef enum logic {
    GPR = 1'b0,
    FPR = 1'b1
  } reg_typ_t;

  // ----------------------------------------
  // Data and ids
  // ----------------------------------------
  typedef logic [`FPU_FLEN-1:0] flen_t;
  typedef logic [`FPU_RNID_W-1:0] rnid_t;
  typedef logic [`FPU_CMT_ID_W-1:0] cmt_id_t;

endpackage

// File: hw/fpu_issue_decode.sv
`timescale 1ns/1ps
`include "fpu_params.svh"

module fpu_issue_decode (
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  input  logic                   i_issue_valid,
  input  fpu_op_pkg::fpu_op_t    i_issue_op,
  input  fpu_pipe_pkg::cmt_id_t  i_issue_cmt_id,
  input  fpu_pipe_pkg::rnid_t    i_issue_rs1_rnid,
  input  fpu_pipe_pkg::rnid_t    i_issue_rs2_rnid,
  input  fpu_pipe_pkg::rnid_t    i_issue_rd_rnid,
  output logic                   o_ex1_valid,
  output fpu_op_pkg::fpu_op_t    o_ex1_op,
  output fpu_pipe_pkg::cmt_id_t  o_ex1_cmt_id,
  output fpu_pipe_pkg::rnid_t    o_ex1_rd_rnid,
  output fpu_pipe_pkg::reg_typ_t o_ex1_rd_typ,
  output logic                   o_ex1_src_need [`FPU_NUM_SRC],
  output fpu_pipe_pkg::reg_typ_t o_ex1_src_typ  [`FPU_NUM_SRC],
  output fpu_pipe_pkg::rnid_t    o_ex1_src_rnid [`FPU_NUM_SRC]
);

  logic                   w_uses_rs2;
  fpu_pipe_pkg::reg_typ_t w_rs1_typ;
  fpu_pipe_pkg::reg_typ_t w_rd_typ;

  // ----------------------------------------
  // Operand and destination banks
  // ----------------------------------------
  always_comb begin
    w_uses_rs2 = 1'b0;
    w_rs1_typ  = fpu_pipe_pkg::FPR;
    w_rd_typ   = fpu_pipe_pkg::FPR;
    case (i_issue_op)
      fpu_op_pkg::OP_FMV_X_W,
      fpu_op_pkg::OP_FMV_X_D: w_rd_typ = fpu_pipe_pkg::GPR;
      fpu_op_pkg::OP_FMV_W_X,
      fpu_op_pkg::OP_FMV_D_X: w_rs1_typ = fpu_pipe_pkg::GPR;
      default: w_uses_rs2 = 1'b1;
    endcase
  end

  // Valid and read enables
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_ex1_valid       <= 1'b0;
      o_ex1_src_need[0] <= 1'b0;
      o_ex1_src_need[1] <= 1'b0;
    end else begin
      o_ex1_valid       <= i_issue_valid;
      o_ex1_src_need[0] <= i_issue_valid;
      o_ex1_src_need[1] <= i_issue_valid & w_uses_rs2;
    end
  end

  always_ff @(posedge i_clk) begin
    o_ex1_op          <= i_issue_op;
    o_ex1_cmt_id      <= i_issue_cmt_id;
    o_ex1_rd_rnid     <= i_issue_rd_rnid;
    o_ex1_rd_typ      <= w_rd_typ;
    o_ex1_src_typ[0]  <= w_rs1_typ;
    o_ex1_src_typ[1]  <= fpu_pipe_pkg::FPR;
    o_ex1_src_rnid[0] <= i_issue_rs1_rnid;
    o_ex1_src_rnid[1] <= i_issue_rs2_rnid;
  end

  a_issue_op_known : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_issue_valid |-> !$isunknown(i_issue_op) && (i_issue_op inside {
      fpu_op_pkg::OP_FMV_X_W, fpu_op_pkg::OP_FMV_W_X, fpu_op_pkg::OP_FMV_X_D,
      fpu_op_pkg::OP_FMV_D_X, fpu_op_pkg::OP_FSGNJ_S, fpu_op_pkg::OP_FSGNJN_S,
      fpu_op_pkg::OP_FSGNJX_S, fpu_op_pkg::OP_FSGNJ_D, fpu_op_pkg::OP_FSGNJN_D,
      fpu_op_pkg::OP_FSGNJX_D}));

endmodule

// File: hw/fpu_operand_fwd.sv
`timescale 1ns/1ps
`include "fpu_params.svh"

module fpu_operand_fwd (
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  input  logic                   i_ex1_need,
  input  fpu_pipe_pkg::reg_typ_t i_ex1_typ,
  input  fpu_pipe_pkg::rnid_t    i_ex1_rnid,
  input  fpu_pipe_pkg::flen_t    i_rd_data,
  input  logic                   i_wb_bus_valid [`FPU_WB_BUS_NUM],
  input  fpu_pipe_pkg::reg_typ_t i_wb_bus_typ   [`FPU_WB_BUS_NUM],
  input  fpu_pipe_pkg::rnid_t    i_wb_bus_rnid  [`FPU_WB_BUS_NUM],
  input  fpu_pipe_pkg::flen_t    i_wb_bus_data  [`FPU_WB_BUS_NUM],
  output logic                   o_rd_valid,
  output fpu_pipe_pkg::reg_typ_t o_rd_typ,
  output fpu_pipe_pkg::rnid_t    o_rd_rnid,
  output fpu_pipe_pkg::flen_t    o_ex2_data
);

  logic [`FPU_WB_BUS_NUM-1:0] w_ex1_hit;
  logic [`FPU_WB_BUS_NUM-1:0] w_ex2_hit;
  fpu_pipe_pkg::flen_t        w_ex1_fwd_data;
  fpu_pipe_pkg::flen_t        w_ex2_fwd_data;
  fpu_pipe_pkg::flen_t        w_ex1_data;

  logic                   r_ex2_need;
  fpu_pipe_pkg::reg_typ_t r_ex2_typ;
  fpu_pipe_pkg::rnid_t    r_ex2_rnid;
  fpu_pipe_pkg::flen_t    r_ex2_data;

  // Register-file read request in ex1
  assign o_rd_valid = i_ex1_need;
  assign o_rd_typ   = i_ex1_typ;
  assign o_rd_rnid  = i_ex1_rnid;

  // ----------------------------------------
  // Bus compare, both stages
  // ----------------------------------------
  always_comb begin
    w_ex1_fwd_data = '0;
    w_ex2_fwd_data = '0;
    for (int b = 0; b < `FPU_WB_BUS_NUM; b++) begin
      w_ex1_hit[b] = i_ex1_need & i_wb_bus_valid[b] &
                     (i_wb_bus_typ[b] == i_ex1_typ) & (i_wb_bus_rnid[b] == i_ex1_rnid);
      w_ex2_hit[b] = r_ex2_need & i_wb_bus_valid[b] &
                     (i_wb_bus_typ[b] == r_ex2_typ) & (i_wb_bus_rnid[b] == r_ex2_rnid);
      // Hits are one-hot so an OR is enough
      w_ex1_fwd_data = w_ex1_fwd_data | ({`FPU_FLEN{w_ex1_hit[b]}} & i_wb_bus_data[b]);
      w_ex2_fwd_data = w_ex2_fwd_data | ({`FPU_FLEN{w_ex2_hit[b]}} & i_wb_bus_data[b]);
    end
  end

  assign w_ex1_data = |w_ex1_hit ? w_ex1_fwd_data : i_rd_data;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex2_need <= 1'b0;
    end else begin
      r_ex2_need <= i_ex1_need;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex2_typ  <= i_ex1_typ;
    r_ex2_rnid <= i_ex1_rnid;
    r_ex2_data <= w_ex1_data;
  end

  // Late write in ex2 wins over the registered value
  assign o_ex2_data = |w_ex2_hit ? w_ex2_fwd_data : r_ex2_data;

  a_bus_hit_onehot : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    $onehot0(w_ex1_hit) && $onehot0(w_ex2_hit));

endmodule

// File: hw/fpu_move_sign_exec.sv
`timescale 1ns/1ps
`include "fpu_params.svh"

module fpu_move_sign_exec (
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  input  logic                   i_ex1_valid,
  input  fpu_op_pkg::fpu_op_t    i_ex1_op,
  input  fpu_pipe_pkg::cmt_id_t  i_ex1_cmt_id,
  input  fpu_pipe_pkg::rnid_t    i_ex1_rd_rnid,
  input  fpu_pipe_pkg::reg_typ_t i_ex1_rd_typ,
  input  fpu_pipe_pkg::flen_t    i_ex2_rs1,
  input  fpu_pipe_pkg::flen_t    i_ex2_rs2,
  output logic                   o_wb_valid,
  output fpu_pipe_pkg::reg_typ_t o_wb_typ,
  output fpu_pipe_pkg::rnid_t    o_wb_rnid,
  output fpu_pipe_pkg::flen_t    o_wb_data,
  output fpu_pipe_pkg::cmt_id_t  o_done_cmt_id
);

  localparam int MSB = `FPU_FLEN - 1;

  logic                   r_ex2_valid;
  fpu_op_pkg::fpu_op_t    r_ex2_op;
  fpu_pipe_pkg::cmt_id_t  r_ex2_cmt_id;
  fpu_pipe_pkg::rnid_t    r_ex2_rd_rnid;
  fpu_pipe_pkg::reg_typ_t r_ex2_rd_typ;

  fpu_pipe_pkg::flen_t w_rs1_canon;
  fpu_pipe_pkg::flen_t w_rs2_canon;
  fpu_pipe_pkg::flen_t w_ex2_res;

  // ----------------------------------------
  // ex2 control
  // ----------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex2_valid <= 1'b0;
    end else begin
      r_ex2_valid <= i_ex1_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex2_op      <= i_ex1_op;
    r_ex2_cmt_id  <= i_ex1_cmt_id;
    r_ex2_rd_rnid <= i_ex1_rd_rnid;
    r_ex2_rd_typ  <= i_ex1_rd_typ;
  end

  // Unboxed singles read as canonical NaN
  assign w_rs1_canon = (&i_ex2_rs1[63:32]) ? i_ex2_rs1 : `FPU_CANON_NAN_S;
  assign w_rs2_canon = (&i_ex2_rs2[63:32]) ? i_ex2_rs2 : `FPU_CANON_NAN_S;

  always_comb begin
    case (r_ex2_op)
      fpu_op_pkg::OP_FMV_X_W: w_ex2_res = {{32{i_ex2_rs1[31]}}, i_ex2_rs1[31:0]};
      fpu_op_pkg::OP_FMV_W_X: w_ex2_res = {32'hffff_ffff, i_ex2_rs1[31:0]};
      fpu_op_pkg::OP_FMV_X_D,
      fpu_op_pkg::OP_FMV_D_X: w_ex2_res = i_ex2_rs1;
      fpu_op_pkg::OP_FSGNJ_D:  w_ex2_res = {i_ex2_rs2[MSB], i_ex2_rs1[MSB-1:0]};
      fpu_op_pkg::OP_FSGNJN_D: w_ex2_res = {~i_ex2_rs2[MSB], i_ex2_rs1[MSB-1:0]};
      fpu_op_pkg::OP_FSGNJX_D:
        w_ex2_res = {i_ex2_rs1[MSB] ^ i_ex2_rs2[MSB], i_ex2_rs1[MSB-1:0]};
      fpu_op_pkg::OP_FSGNJ_S:
        w_ex2_res = {w_rs1_canon[63:32], w_rs2_canon[31], w_rs1_canon[30:0]};
      fpu_op_pkg::OP_FSGNJN_S:
        w_ex2_res = {w_rs1_canon[63:32], ~w_rs2_canon[31], w_rs1_canon[30:0]};
      fpu_op_pkg::OP_FSGNJX_S:
        w_ex2_res = {w_rs1_canon[63:32], w_rs1_canon[31] ^ w_rs2_canon[31],
                     w_rs1_canon[30:0]};
      default: w_ex2_res = '0;
    endcase
  end

  // ----------------------------------------
  // ex3 write-back
  // ----------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_wb_valid <= 1'b0;
    end else begin
      o_wb_valid <= r_ex2_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    o_wb_typ      <= r_ex2_rd_typ;
    o_wb_rnid     <= r_ex2_rd_rnid;
    o_wb_data     <= w_ex2_res;
    o_done_cmt_id <= r_ex2_cmt_id;
  end

  a_wb_valid_known : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !$isunknown(o_wb_valid));

endmodule

// File: hw/fpu_fast_pipe.sv
`timescale 1ns/1ps
`include "fpu_params.svh"

module fpu_fast_pipe (
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  input  logic                   i_issue_valid,
  input  fpu_op_pkg::fpu_op_t    i_issue_op,
  input  fpu_pipe_pkg::cmt_id_t  i_issue_cmt_id,
  input  fpu_pipe_pkg::rnid_t    i_issue_rs1_rnid,
  input  fpu_pipe_pkg::rnid_t    i_issue_rs2_rnid,
  input  fpu_pipe_pkg::rnid_t    i_issue_rd_rnid,
  output logic                   o_src_rd_valid [`FPU_NUM_SRC],
  output fpu_pipe_pkg::reg_typ_t o_src_rd_typ   [`FPU_NUM_SRC],
  output fpu_pipe_pkg::rnid_t    o_src_rd_rnid  [`FPU_NUM_SRC],
  input  fpu_pipe_pkg::flen_t    i_src_rd_data  [`FPU_NUM_SRC],
  input  logic                   i_wb_bus_valid [`FPU_WB_BUS_NUM],
  input  fpu_pipe_pkg::reg_typ_t i_wb_bus_typ   [`FPU_WB_BUS_NUM],
  input  fpu_pipe_pkg::rnid_t    i_wb_bus_rnid  [`FPU_WB_BUS_NUM],
  input  fpu_pipe_pkg::flen_t    i_wb_bus_data  [`FPU_WB_BUS_NUM],
  output logic                   o_wb_valid,
  output fpu_pipe_pkg::reg_typ_t o_wb_typ,
  output fpu_pipe_pkg::rnid_t    o_wb_rnid,
  output fpu_pipe_pkg::flen_t    o_wb_data,
  output fpu_pipe_pkg::cmt_id_t  o_done_cmt_id
);

  logic                   w_ex1_valid;
  fpu_op_pkg::fpu_op_t    w_ex1_op;
  fpu_pipe_pkg::cmt_id_t  w_ex1_cmt_id;
  fpu_pipe_pkg::rnid_t    w_ex1_rd_rnid;
  fpu_pipe_pkg::reg_typ_t w_ex1_rd_typ;
  logic                   w_ex1_src_need [`FPU_NUM_SRC];
  fpu_pipe_pkg::reg_typ_t w_ex1_src_typ  [`FPU_NUM_SRC];
  fpu_pipe_pkg::rnid_t    w_ex1_src_rnid [`FPU_NUM_SRC];
  fpu_pipe_pkg::flen_t    w_ex2_src_data [`FPU_NUM_SRC];

  fpu_issue_decode u_decode (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_issue_valid    (i_issue_valid),
    .i_issue_op       (i_issue_op),
    .i_issue_cmt_id   (i_issue_cmt_id),
    .i_issue_rs1_rnid (i_issue_rs1_rnid),
    .i_issue_rs2_rnid (i_issue_rs2_rnid),
    .i_issue_rd_rnid  (i_issue_rd_rnid),
    .o_ex1_valid      (w_ex1_valid),
    .o_ex1_op         (w_ex1_op),
    .o_ex1_cmt_id     (w_ex1_cmt_id),
    .o_ex1_rd_rnid    (w_ex1_rd_rnid),
    .o_ex1_rd_typ     (w_ex1_rd_typ),
    .o_ex1_src_need   (w_ex1_src_need),
    .o_ex1_src_typ    (w_ex1_src_typ),
    .o_ex1_src_rnid   (w_ex1_src_rnid)
  );

  // One forwarding unit per source
  for (genvar s = 0; s < `FPU_NUM_SRC; s++) begin : g_src
    fpu_operand_fwd u_fwd (
      .i_clk          (i_clk),
      .i_reset_n      (i_reset_n),
      .i_ex1_need     (w_ex1_src_need[s]),
      .i_ex1_typ      (w_ex1_src_typ[s]),
      .i_ex1_rnid     (w_ex1_src_rnid[s]),
      .i_rd_data      (i_src_rd_data[s]),
      .i_wb_bus_valid (i_wb_bus_valid),
      .i_wb_bus_typ   (i_wb_bus_typ),
      .i_wb_bus_rnid  (i_wb_bus_rnid),
      .i_wb_bus_data  (i_wb_bus_data),
      .o_rd_valid     (o_src_rd_valid[s]),
      .o_rd_typ       (o_src_rd_typ[s]),
      .o_rd_rnid      (o_src_rd_rnid[s]),
      .o_ex2_data     (w_ex2_src_data[s])
    );
  end

  fpu_move_sign_exec u_exec (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_ex1_valid   (w_ex1_valid),
    .i_ex1_op      (w_ex1_op),
    .i_ex1_cmt_id  (w_ex1_cmt_id),
    .i_ex1_rd_rnid (w_ex1_rd_rnid),
    .i_ex1_rd_typ  (w_ex1_rd_typ),
    .i_ex2_rs1     (w_ex2_src_data[0]),
    .i_ex2_rs2     (w_ex2_src_data[1]),
    .o_wb_valid    (o_wb_valid),
    .o_wb_typ      (o_wb_typ),
    .o_wb_rnid     (o_wb_rnid),
    .o_wb_data     (o_wb_data),
    .o_done_cmt_id (o_done_cmt_id)
  );

endmodule

// File: dv/fpu_fast_pipe_tb.sv
`timescale 1ns/1ps
`include "fpu_params.svh"

module fpu_fast_pipe_tb;

  typedef struct {
    logic                  v;
    fpu_op_pkg::fpu_op_t   op;
    fpu_pipe_pkg::cmt_id_t cmt;
    fpu_pipe_pkg::rnid_t   rs1;
    fpu_pipe_pkg::rnid_t   rs2;
    fpu_pipe_pkg::rnid_t   rd;
  } issue_t;

  typedef struct {
    fpu_pipe_pkg::flen_t    data;
    fpu_pipe_pkg::reg_typ_t typ;
    fpu_pipe_pkg::rnid_t    rnid;
    fpu_pipe_pkg::cmt_id_t  cmt;
  } wb_exp_t;

  logic                   i_clk;
  logic                   i_reset_n;
  logic                   i_issue_valid;
  fpu_op_pkg::fpu_op_t    i_issue_op;
  fpu_pipe_pkg::cmt_id_t  i_issue_cmt_id;
  fpu_pipe_pkg::rnid_t    i_issue_rs1_rnid;
  fpu_pipe_pkg::rnid_t    i_issue_rs2_rnid;
  fpu_pipe_pkg::rnid_t    i_issue_rd_rnid;
  logic                   o_src_rd_valid [`FPU_NUM_SRC];
  fpu_pipe_pkg::reg_typ_t o_src_rd_typ   [`FPU_NUM_SRC];
  fpu_pipe_pkg::rnid_t    o_src_rd_rnid  [`FPU_NUM_SRC];
  fpu_pipe_pkg::flen_t    i_src_rd_data  [`FPU_NUM_SRC];
  logic                   i_wb_bus_valid [`FPU_WB_BUS_NUM];
  fpu_pipe_pkg::reg_typ_t i_wb_bus_typ   [`FPU_WB_BUS_NUM];
  fpu_pipe_pkg::rnid_t    i_wb_bus_rnid  [`FPU_WB_BUS_NUM];
  fpu_pipe_pkg::flen_t    i_wb_bus_data  [`FPU_WB_BUS_NUM];
  logic                   o_wb_valid;
  fpu_pipe_pkg::reg_typ_t o_wb_typ;
  fpu_pipe_pkg::rnid_t    o_wb_rnid;
  fpu_pipe_pkg::flen_t    o_wb_data;
  fpu_pipe_pkg::cmt_id_t  o_done_cmt_id;

  fpu_pipe_pkg::flen_t   gpr_bank [64];
  fpu_pipe_pkg::flen_t   fpr_bank [64];
  wb_exp_t               exp_q [$];
  // In-flight issues with slot 0 in ex1
  issue_t                slot [3];
  fpu_pipe_pkg::cmt_id_t next_cmt;
  fpu_op_pkg::fpu_op_t   ops [10];

  fpu_fast_pipe dut_i (.*);

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  task automatic stop_on_error(string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic value_error(string name, logic [63:0] got, logic [63:0] exp);
    stop_on_error($sformatf("Error at %0t ns: %s = %h, expected %h",
                            $time, name, got, exp));
  endtask

  task automatic check_data(string name, fpu_pipe_pkg::flen_t got, fpu_pipe_pkg::flen_t exp);
    if (got !== exp) value_error(name, got, exp);
  endtask

  task automatic check_typ(string name, fpu_pipe_pkg::reg_typ_t got,
                           fpu_pipe_pkg::reg_typ_t exp);
    if (got !== exp) value_error(name, got, exp);
  endtask

  task automatic check_rnid(string name, fpu_pipe_pkg::rnid_t got, fpu_pipe_pkg::rnid_t exp);
    if (got !== exp) value_error(name, got, exp);
  endtask

  task automatic check_cmt(string name, fpu_pipe_pkg::cmt_id_t got, fpu_pipe_pkg::cmt_id_t exp);
    if (got !== exp) value_error(name, got, exp);
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) value_error(name, got, exp);
  endtask

  // ----------------------------------------
  // Reference
  // ----------------------------------------
  function automatic fpu_pipe_pkg::reg_typ_t rs1_typ(fpu_op_pkg::fpu_op_t op);
    if (op inside {fpu_op_pkg::OP_FMV_W_X, fpu_op_pkg::OP_FMV_D_X}) return fpu_pipe_pkg::GPR;
    return fpu_pipe_pkg::FPR;
  endfunction

  function automatic logic uses_rs2(fpu_op_pkg::fpu_op_t op);
    return !(op inside {fpu_op_pkg::OP_FMV_X_W, fpu_op_pkg::OP_FMV_W_X,
                        fpu_op_pkg::OP_FMV_X_D, fpu_op_pkg::OP_FMV_D_X});
  endfunction

  function automatic void ref_result(input fpu_op_pkg::fpu_op_t op,
      input fpu_pipe_pkg::flen_t rs1, input fpu_pipe_pkg::flen_t rs2,
      output fpu_pipe_pkg::flen_t res, output fpu_pipe_pkg::reg_typ_t rd_typ);
    fpu_pipe_pkg::flen_t a;
    fpu_pipe_pkg::flen_t b;
    a = (rs1[63:32] == '1) ? rs1 : `FPU_CANON_NAN_S;
    b = (rs2[63:32] == '1) ? rs2 : `FPU_CANON_NAN_S;
    rd_typ = fpu_pipe_pkg::FPR;
    res    = rs1;
    case (op)
      fpu_op_pkg::OP_FMV_X_W: begin
        res    = 64'($signed(rs1[31:0]));
        rd_typ = fpu_pipe_pkg::GPR;
      end
      fpu_op_pkg::OP_FMV_W_X: res[63:32] = '1;
      fpu_op_pkg::OP_FMV_X_D: rd_typ = fpu_pipe_pkg::GPR;
      fpu_op_pkg::OP_FSGNJ_D: res[63] = rs2[63];
      fpu_op_pkg::OP_FSGNJN_D: res[63] = !rs2[63];
      fpu_op_pkg::OP_FSGNJX_D: res[63] = rs1[63] ^ rs2[63];
      fpu_op_pkg::OP_FSGNJ_S,
      fpu_op_pkg::OP_FSGNJN_S,
      fpu_op_pkg::OP_FSGNJX_S: begin
        res = a;
        if (op == fpu_op_pkg::OP_FSGNJ_S) res[31] = b[31];
        else if (op == fpu_op_pkg::OP_FSGNJN_S) res[31] = !b[31];
        else res[31] = a[31] ^ b[31];
      end
      default: ;
    endcase
  endfunction

  function automatic fpu_pipe_pkg::flen_t bank_read(fpu_pipe_pkg::reg_typ_t typ,
                                                    fpu_pipe_pkg::rnid_t rnid);
    return (typ == fpu_pipe_pkg::FPR) ? fpr_bank[rnid] : gpr_bank[rnid];
  endfunction

  // ----------------------------------------
  // Register-file model
  // ----------------------------------------
  always @(posedge i_clk) begin
    if (!i_reset_n) begin
      // Odd FPR entries are NaN-boxed
      for (int i = 0; i < 64; i++) begin
        gpr_bank[i] <= {32'h1000_0000 + 32'(i), 32'(i) * 32'h9e37_79b9};
        fpr_bank[i] <= {(i % 2) ? 32'hffff_ffff : 32'hc000_0000 + 32'(i),
                        32'(i) * 32'h85eb_ca6b};
      end
    end else begin
      for (int b = 0; b < `FPU_WB_BUS_NUM; b++) begin
        if (i_wb_bus_valid[b] && i_wb_bus_typ[b] == fpu_pipe_pkg::FPR)
          fpr_bank[i_wb_bus_rnid[b]] <= i_wb_bus_data[b];
        else if (i_wb_bus_valid[b])
          gpr_bank[i_wb_bus_rnid[b]] <= i_wb_bus_data[b];
      end
    end
  end

  always_comb begin
    for (int s = 0; s < `FPU_NUM_SRC; s++)
      i_src_rd_data[s] = (o_src_rd_typ[s] == fpu_pipe_pkg::FPR) ?
                         fpr_bank[o_src_rd_rnid[s]] : gpr_bank[o_src_rd_rnid[s]];
  end

  // Write-back compare on pre-edge values
  always @(posedge i_clk) begin
    wb_exp_t e;
    if (o_wb_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        stop_on_error("Write-back valid with no result outstanding");
      end else begin
        e = exp_q.pop_front();
        check_data("o_wb_data", o_wb_data, e.data);
        check_typ("o_wb_typ", o_wb_typ, e.typ);
        check_rnid("o_wb_rnid", o_wb_rnid, e.rnid);
        check_cmt("o_done_cmt_id", o_done_cmt_id, e.cmt);
      end
    end else if (o_wb_valid !== 1'b0) begin
      stop_on_error("Write-back valid is unknown");
    end else if (exp_q.size() != 0) begin
      stop_on_error("Expected write-back did not arrive 3 cycles after its issue");
    end
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  function automatic fpu_pipe_pkg::flen_t rand_val();
    return {($urandom_range(0, 1) ? 32'hffff_ffff : $urandom), $urandom};
  endfunction

  function automatic logic pipe_busy();
    return slot[0].v || slot[1].v || slot[2].v || exp_q.size() != 0;
  endfunction

  task automatic next_cycle();
    wb_exp_t             e;
    fpu_pipe_pkg::flen_t rs1;
    fpu_pipe_pkg::flen_t rs2;
    @(negedge i_clk);
    // Leaving ex2 so the model now holds the final sources
    if (slot[2].v) begin
      rs1 = bank_read(rs1_typ(slot[2].op), slot[2].rs1);
      rs2 = bank_read(fpu_pipe_pkg::FPR, slot[2].rs2);
      ref_result(slot[2].op, rs1, rs2, e.data, e.typ);
      e.rnid = slot[2].rd;
      e.cmt  = slot[2].cmt;
      exp_q.push_back(e);
    end
    check_flag("o_src_rd_valid[0]", o_src_rd_valid[0], slot[0].v);
    check_flag("o_src_rd_valid[1]", o_src_rd_valid[1], slot[0].v && uses_rs2(slot[0].op));
    if (slot[0].v) begin
      check_typ("o_src_rd_typ[0]", o_src_rd_typ[0], rs1_typ(slot[0].op));
      check_rnid("o_src_rd_rnid[0]", o_src_rd_rnid[0], slot[0].rs1);
    end
    if (slot[0].v && uses_rs2(slot[0].op)) begin
      check_typ("o_src_rd_typ[1]", o_src_rd_typ[1], fpu_pipe_pkg::FPR);
      check_rnid("o_src_rd_rnid[1]", o_src_rd_rnid[1], slot[0].rs2);
    end
    slot[2]       = slot[1];
    slot[1]       = slot[0];
    slot[0].v     = 1'b0;
    i_issue_valid = 1'b0;
    for (int b = 0; b < `FPU_WB_BUS_NUM; b++)
      i_wb_bus_valid[b] = 1'b0;
  endtask

  task automatic send_issue(fpu_op_pkg::fpu_op_t op, fpu_pipe_pkg::rnid_t rs1,
                            fpu_pipe_pkg::rnid_t rs2, fpu_pipe_pkg::rnid_t rd);
    slot[0]          = '{1'b1, op, next_cmt, rs1, rs2, rd};
    i_issue_valid    = 1'b1;
    i_issue_op       = op;
    i_issue_cmt_id   = next_cmt;
    i_issue_rs1_rnid = rs1;
    i_issue_rs2_rnid = rs2;
    i_issue_rd_rnid  = rd;
    next_cmt++;
  endtask

  task automatic send_bus(int b, fpu_pipe_pkg::reg_typ_t typ, fpu_pipe_pkg::rnid_t rnid,
                          fpu_pipe_pkg::flen_t data);
    i_wb_bus_valid[b] = 1'b1;
    i_wb_bus_typ[b]   = typ;
    i_wb_bus_rnid[b]  = rnid;
    i_wb_bus_data[b]  = data;
  endtask

  initial begin
    int n;
    void'($urandom(32'h62d3cd0a));
    ops = '{fpu_op_pkg::OP_FMV_X_W, fpu_op_pkg::OP_FMV_W_X, fpu_op_pkg::OP_FMV_X_D,
            fpu_op_pkg::OP_FMV_D_X, fpu_op_pkg::OP_FSGNJ_S, fpu_op_pkg::OP_FSGNJN_S,
            fpu_op_pkg::OP_FSGNJX_S, fpu_op_pkg::OP_FSGNJ_D, fpu_op_pkg::OP_FSGNJN_D,
            fpu_op_pkg::OP_FSGNJX_D};
    next_cmt         = '0;
    i_reset_n        = 1'b1;
    i_issue_valid    = 1'b0;
    i_issue_op       = fpu_op_pkg::OP_FMV_X_W;
    i_issue_cmt_id   = '0;
    i_issue_rs1_rnid = '0;
    i_issue_rs2_rnid = '0;
    i_issue_rd_rnid  = '0;
    for (int b = 0; b < `FPU_WB_BUS_NUM; b++) begin
      i_wb_bus_valid[b] = 1'b0;
      i_wb_bus_typ[b]   = fpu_pipe_pkg::GPR;
      i_wb_bus_rnid[b]  = '0;
      i_wb_bus_data[b]  = '0;
    end
    for (int s = 0; s < 3; s++)
      slot[s].v = 1'b0;
    // Reset edge before the first clock edge
    #1 i_reset_n = 1'b0;
    repeat (8) next_cycle();
    i_reset_n = 1'b1;
    repeat (3) next_cycle();

    // Moves with idle buses
    for (int k = 0; k < 4; k++) begin
      send_issue(ops[k], 6'(k + 1), 6'(k + 2), 6'(k + 9));
      repeat (4) next_cycle();
    end

    // Boxed, unboxed and double operands
    send_bus(0, fpu_pipe_pkg::FPR, 6'd1, 64'hffff_ffff_c040_0000);
    send_bus(1, fpu_pipe_pkg::FPR, 6'd2, 64'hffff_ffff_3f80_0000);
    next_cycle();
    send_bus(0, fpu_pipe_pkg::FPR, 6'd3, 64'h0000_0000_bf80_0000);
    send_bus(1, fpu_pipe_pkg::FPR, 6'd4, 64'hbff0_0000_0000_0000);
    for (int k = 4; k < 10; k++) begin
      next_cycle();
      send_issue(ops[k], 6'd1, 6'd2, 6'd20);
      next_cycle();
      send_issue(ops[k], 6'd3, 6'd2, 6'd21);
      next_cycle();
      send_issue(ops[k], 6'd4, 6'd3, 6'd22);
    end

    // rs1 rewritten in ex1 and rs2 in ex2, then both once too late
    next_cycle();
    send_issue(fpu_op_pkg::OP_FSGNJX_D, 6'd5, 6'd6, 6'd23);
    next_cycle();
    send_bus(0, fpu_pipe_pkg::FPR, 6'd5, 64'h0123_4567_89ab_cdef);
    next_cycle();
    send_bus(1, fpu_pipe_pkg::FPR, 6'd6, 64'h7ff0_0000_0000_0001);
    next_cycle();
    send_bus(0, fpu_pipe_pkg::FPR, 6'd5, 64'hfedc_ba98_7654_3210);
    send_bus(1, fpu_pipe_pkg::FPR, 6'd6, 64'hffff_ffff_ffff_ffff);

    // Back-to-back random issues under random bus traffic
    for (n = 0; n < 300; n++) begin
      next_cycle();
      send_issue(ops[$urandom_range(0, 9)], 6'($urandom_range(0, 7)),
                 6'($urandom_range(0, 7)), 6'($urandom_range(0, 63)));
      for (int b = 0; b < `FPU_WB_BUS_NUM; b++)
        if ($urandom_range(0, 1))
          send_bus(b, fpu_pipe_pkg::reg_typ_t'($urandom_range(0, 1)),
                   6'($urandom_range(0, 7)), rand_val());
      if (i_wb_bus_valid[0] && i_wb_bus_valid[1] && i_wb_bus_typ[0] == i_wb_bus_typ[1] &&
          i_wb_bus_rnid[0] == i_wb_bus_rnid[1])
        i_wb_bus_valid[1] = 1'b0;
    end

    n = 0;
    while (pipe_busy() && n < 10) begin
      next_cycle();
      n++;
    end
    if (pipe_busy()) begin
      stop_on_error("Timeout while waiting for outstanding write-backs to drain");
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

// File: project.f
+incdir+hw
hw/fpu_op_pkg.sv
hw/fpu_pipe_pkg.sv
hw/fpu_issue_decode.sv
hw/fpu_operand_fwd.sv
hw/fpu_move_sign_exec.sv
hw/fpu_fast_pipe.sv
dv/fpu_fast_pipe_tb.sv
